// ==== Makefile ====
TOP := tb_board_specific_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f board_specific_top.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== board_specific_top.f ====
+incdir+rtl
rtl/mic_meter_pkg.sv
rtl/i2s_mic_receiver.sv
rtl/peak_meter.sv
rtl/seven_seg_scan.sv
rtl/mic_meter_top.sv
rtl/board_specific_top.sv
sim/tb_clock_gen.sv
sim/board_specific_top_sva.sv
sim/tb_board_specific_top.sv

// ==== rtl/board_specific_top.sv ====
`timescale 1ns/10ps

module board_specific_top
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [3:0] key,
    input  logic [9:0] sw,
    output logic [9:0] ledr,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5,
    input  logic       mic_sd,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr
);

    import mic_meter_pkg::*;

    seg_t       abcdefgh;
    seg_t       hgfedcba;
    digit_sel_t digit;
    led_bar_t   led;
    logic [6:0] hex_gated [$bits(digit_sel_t)];

    // keys on the board read low when pressed.
    mic_meter_top i_top
    (
        .clk      (   clk      ),
        .arst_n   (   arst_n   ),
        .key      ( ~ key      ),
        .sw       (   sw       ),
        .mic_sd   (   mic_sd   ),
        .mic_sck  (   mic_sck  ),
        .mic_ws   (   mic_ws   ),
        .led      (   led      ),
        .abcdefgh (   abcdefgh ),
        .digit    (   digit    )
    );

    assign ledr = led;

    // the display pins run from segment a at bit 0 up to the dot at bit 7.
    for (genvar i = 0; i < $bits(seg_t); i++)
    begin : rev
        assign hgfedcba[i] = abcdefgh[$left(abcdefgh) - i];
    end

    // the segments are active low, and an idle digit stays dark.
    for (genvar n = 0; n < $bits(digit_sel_t); n++)
    begin : gate
        assign hex_gated[n] = digit[n] ? ~ hgfedcba[6:0] : '1;
    end

    assign hex0 = hex_gated[0];
    assign hex1 = hex_gated[1];
    assign hex2 = hex_gated[2];
    assign hex3 = hex_gated[3];
    assign hex4 = hex_gated[4];
    assign hex5 = hex_gated[5];

    // a low L/R pin puts the microphone on the left channel.
    assign mic_lr = 1'b0;

endmodule

// ==== rtl/i2s_mic_receiver.sv ====
`timescale 1ns/10ps
`include "mic_meter_consts.svh"

module i2s_mic_receiver
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        sd,
    output logic                        sck,
    output logic                        ws,
    output mic_meter_pkg::sample_beat_t beat
);

    import mic_meter_pkg::*;

    localparam int div_w  = $clog2(`MIC_SCK_HALF + 1);
    localparam int bit_w  = $clog2(`MIC_FRAME_BITS);
    localparam int data_w = $clog2(`MIC_SAMPLE_W);

    logic [div_w - 1:0]  div_cnt;
    logic                sck_tick;
    logic                sck_rise;
    logic                sck_fall;
    logic [bit_w - 1:0]  bit_cnt;
    logic [bit_w - 1:0]  bit_cnt_next;
    logic [data_w - 1:0] data_cnt;
    logic                valid_q;
    sample_t             shift_reg;
    rx_state_t           state;

    assign sck_tick     = (div_cnt == div_w'(`MIC_SCK_HALF - 1));
    assign sck_rise     = sck_tick && !sck;
    assign sck_fall     = sck_tick && sck;
    assign bit_cnt_next = bit_cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= !sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end

    // the bit counter starts on the last bit of a frame, so the first
    // falling edge of sck opens a new frame and pulls ws low.
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            bit_cnt <= '1;
            ws      <= 1'b1;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt_next;
            ws      <= (bit_cnt_next >= bit_w'(`MIC_FRAME_BITS / 2));
        end

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            state    <= wait_left;
            data_cnt <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;

            case (state)
                wait_left:
                    if (sck_fall && bit_cnt == '1)
                        state <= skip_bit;

                // I2S puts the MSB one sck period after ws changes.
                skip_bit:
                    if (sck_rise)
                    begin
                        state    <= shift_data;
                        data_cnt <= '0;
                    end

                shift_data:
                    if (sck_rise)
                    begin
                        data_cnt <= data_cnt + 1'b1;

                        if (data_cnt == data_w'(`MIC_SAMPLE_W - 1))
                        begin
                            state   <= wait_frame_end;
                            valid_q <= 1'b1;
                        end
                    end

                wait_frame_end:
                    if (ws)
                        state <= wait_left;

                default:
                    state <= wait_left;
            endcase
        end

    always_ff @(posedge clk)
        if (state == shift_data && sck_rise)
            shift_reg <= {shift_reg[`MIC_SAMPLE_W - 2:0], sd};

    // the shift register holds still until the next frame, so it serves as the sample.
    assign beat = '{valid: valid_q, sample: shift_reg};

endmodule

// ==== rtl/mic_meter_consts.svh ====
`ifndef MIC_METER_CONSTS_SVH
`define MIC_METER_CONSTS_SVH

// width of one microphone sample in bits.
`define MIC_SAMPLE_W   24

// clk cycles per half period of the serial clock.
`define MIC_SCK_HALF   4

// serial clock periods per I2S frame, half of them per channel.
`define MIC_FRAME_BITS 64

// clk cycles that each display digit stays active.
`define SEG_SCAN_DIV   16

// number of LEDs in the bar graph.
`define LED_BAR_W      10

// bit index of the magnitude below which no LED lights.
`define LED_BAR_BASE   13

`endif

// ==== rtl/mic_meter_pkg.sv ====
`include "mic_meter_consts.svh"

package mic_meter_pkg;

    typedef logic signed [`MIC_SAMPLE_W - 1:0] sample_t;
    typedef logic        [`MIC_SAMPLE_W - 1:0] magnitude_t;

    // segment pattern, bit 7 is segment a and bit 0 is the decimal point.
    typedef logic [7:0]              seg_t;
    typedef logic [5:0]              digit_sel_t;
    typedef logic [`LED_BAR_W - 1:0] led_bar_t;

    typedef struct packed
    {
        logic    valid;
        sample_t sample;
    } sample_beat_t;

    typedef struct packed
    {
        magnitude_t peak;
        magnitude_t live;
    } meter_view_t;

    typedef enum logic [1:0]
    {
        wait_left,
        skip_bit,
        shift_data,
        wait_frame_end
    } rx_state_t;

endpackage

// ==== rtl/mic_meter_top.sv ====
`timescale 1ns/10ps

module mic_meter_top
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [3:0]                key,
    input  logic [9:0]                sw,
    input  logic                      mic_sd,
    output logic                      mic_sck,
    output logic                      mic_ws,
    output mic_meter_pkg::led_bar_t   led,
    output mic_meter_pkg::seg_t       abcdefgh,
    output mic_meter_pkg::digit_sel_t digit
);

    import mic_meter_pkg::*;

    sample_beat_t beat;
    meter_view_t  view;
    magnitude_t   shown;

    i2s_mic_receiver i_receiver
    (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sd     ( mic_sd  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .beat   ( beat    )
    );

    peak_meter i_meter
    (
        .clk     ( clk    ),
        .arst_n  ( arst_n ),
        .clear   ( key[0] ),
        .beat    ( beat   ),
        .view    ( view   ),
        .led_bar ( led    )
    );

    // switch 0 up shows the latest magnitude, down shows the held peak.
    assign shown = sw[0] ? view.live : view.peak;

    seven_seg_scan i_scan
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .value    ( shown    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== rtl/peak_meter.sv ====
`timescale 1ns/10ps
`include "mic_meter_consts.svh"

module peak_meter
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        clear,
    input  mic_meter_pkg::sample_beat_t beat,
    output mic_meter_pkg::meter_view_t  view,
    output mic_meter_pkg::led_bar_t     led_bar
);

    import mic_meter_pkg::*;

    logic [1:0] clear_sync;
    magnitude_t mag;
    magnitude_t peak_q;
    magnitude_t live_q;

    // LED i lights when the leading one sits above LED_BAR_BASE + i.
    function automatic led_bar_t thermometer(input magnitude_t m);
        led_bar_t bar;

        for (int i = 0; i < `LED_BAR_W; i++)
            bar[i] = ((m >> (`LED_BAR_BASE + 1 + i)) != '0);

        return bar;
    endfunction

    // negating -2^23 wraps back to 0x800000, which read unsigned is the right magnitude.
    assign mag = beat.sample[`MIC_SAMPLE_W - 1] ? magnitude_t'(-beat.sample)
                                               : magnitude_t'(beat.sample);

    // the key is not related to clk, so it passes two flops first.
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            clear_sync <= '0;
        else
            clear_sync <= {clear_sync[0], clear};

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            live_q  <= '0;
            led_bar <= '0;
        end
        else if (beat.valid)
        begin
            live_q  <= mag;
            led_bar <= thermometer(mag);
        end

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            peak_q <= '0;
        else if (clear_sync[1])
            peak_q <= '0;
        else if (beat.valid && mag > peak_q)
            peak_q <= mag;

    assign view = '{peak: peak_q, live: live_q};

endmodule

// ==== rtl/seven_seg_scan.sv ====
`timescale 1ns/10ps
`include "mic_meter_consts.svh"

module seven_seg_scan
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  mic_meter_pkg::magnitude_t value,
    output mic_meter_pkg::seg_t       abcdefgh,
    output mic_meter_pkg::digit_sel_t digit
);

    import mic_meter_pkg::*;

    localparam int scan_w = $clog2(`SEG_SCAN_DIV);

    logic [scan_w - 1:0] scan_cnt;
    logic [3:0]          nibble;

    // no digit is active right after reset; digit 0 starts on the next cycle.
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            digit    <= '0;
            scan_cnt <= '0;
        end
        else if (digit == '0)
        begin
            digit    <= digit_sel_t'(1);
            scan_cnt <= '0;
        end
        else if (scan_cnt == scan_w'(`SEG_SCAN_DIV - 1))
        begin
            digit    <= {digit[$left(digit) - 1:0], digit[$left(digit)]};
            scan_cnt <= '0;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end

    always_comb
    begin
        nibble = '0;

        for (int k = 0; k < $bits(digit_sel_t); k++)
            if (digit[k])
                nibble = value[4 * k +: 4];
    end

    always_comb
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            4'hf: abcdefgh = 8'b1000_1110;
            default: abcdefgh = 8'b0000_0010;
        endcase

endmodule

// ==== sim/board_specific_top_sva.sv ====
`timescale 1ns/10ps
`include "mic_meter_consts.svh"

module meter_assertions
(
    input logic                      clk,
    input logic                      arst_n,
    input logic                      sck,
    input logic                      valid,
    input mic_meter_pkg::digit_sel_t digit,
    input mic_meter_pkg::led_bar_t   led_bar
);

    import mic_meter_pkg::*;

    logic [3:0] settle_cnt;
    logic       settled;
    led_bar_t   led_next;

    // sck and the digit select start their regular pattern a few cycles after reset.
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            settle_cnt <= '0;
        else if (!settled)
            settle_cnt <= settle_cnt + 4'd1;

    assign settled  = (settle_cnt == 4'd8);
    assign led_next = led_bar + led_bar_t'(1);

    sck_toggles: assert property (@(posedge clk) disable iff (!arst_n)
        settled |-> !(sck == $past(sck) && sck == $past(sck, 2)
                      && sck == $past(sck, 3) && sck == $past(sck, 4)))
        else $error("sck held its level for more than %0d cycles", `MIC_SCK_HALF);

    valid_single: assert property (@(posedge clk) disable iff (!arst_n)
        valid |=> !valid)
        else $error("sample valid was high for two cycles in a row");

    digit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        settled |-> $onehot(digit))
        else $error("digit select is not one-hot");

    // a thermometer code plus one has no bit in common with itself.
    led_thermometer: assert property (@(posedge clk) disable iff (!arst_n)
        (led_next & led_bar) == led_bar_t'(0))
        else $error("LED bar is not a thermometer code");

endmodule

bind mic_meter_top meter_assertions checks
(
    .clk     ( clk        ),
    .arst_n  ( arst_n     ),
    .sck     ( mic_sck    ),
    .valid   ( beat.valid ),
    .digit   ( digit      ),
    .led_bar ( led        )
);

// ==== sim/tb_board_specific_top.sv ====
`timescale 1ns/10ps
`include "mic_meter_consts.svh"

module tb_board_specific_top;

    localparam int ws_timeout = 4 * `MIC_FRAME_BITS * 2 * `MIC_SCK_HALF;
    localparam int n_rows     = 16;

    // one row of the table holds the stimulus first and the expected results after it.
    typedef struct packed
    {
        logic [23:0] sample;
        logic        rnd;
        logic        clear;
        logic        sw0;
        logic [23:0] peak;
        logic [3:0]  leds;
        logic [23:0] shown;
    } row_t;

    // the standard hex font keeps segment a in bit 0 and has lit segments as ones.
    localparam logic [6:0] hex_font [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
                                             7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c,
                                             7'h39, 7'h5e, 7'h79, 7'h71};

    logic        clk;
    logic        arst_n = 1'b0;
    logic [3:0]  key    = 4'hf;
    logic [9:0]  sw     = '0;
    logic        mic_sd = 1'b0;
    logic [9:0]  ledr;
    logic [6:0]  hex [6];
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;

    row_t        rows [n_rows];
    int          errors   = 0;
    int          timeouts = 0;
    integer      seed     = 25;
    logic [23:0] cur_sample = '0;
    int          fall_cnt   = 0;
    logic        prev_sck   = 1'b0;
    logic        prev_ws    = 1'b1;

    tb_clock_gen #(.period(20)) i_clock (.clk(clk));

    board_specific_top uut
    (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .key     ( key     ),
        .sw      ( sw      ),
        .ledr    ( ledr    ),
        .hex0    ( hex[0]  ),
        .hex1    ( hex[1]  ),
        .hex2    ( hex[2]  ),
        .hex3    ( hex[3]  ),
        .hex4    ( hex[4]  ),
        .hex5    ( hex[5]  ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .mic_lr  ( mic_lr  )
    );

    // the microphone model puts the skipped bit on the fall that opens a frame
    // and bits 23 down to 0 of the current sample on the next 24 falls.
    always @(negedge clk)
    begin
        if (prev_sck && !mic_sck)
        begin
            if (prev_ws && !mic_ws)
                fall_cnt = 0;
            else
                fall_cnt = fall_cnt + 1;

            if (!mic_ws && fall_cnt >= 1 && fall_cnt <= 24)
                mic_sd <= cur_sample[24 - fall_cnt];
            else
                mic_sd <= 1'b0;
        end

        prev_sck <= mic_sck;
        prev_ws  <= mic_ws;
    end

    function automatic logic [23:0] magnitude(input logic [23:0] s);
        return s[23] ? (~s + 24'd1) : s;
    endfunction

    // the number of lit LEDs is the leading-one index minus 13 and never below zero.
    function automatic logic [3:0] led_count(input logic [23:0] m);
        int top;

        top = -1;
        for (int i = 0; i < 24; i++)
            if (m[i])
                top = i;

        return (top < 14) ? 4'd0 : 4'(top - 13);
    endfunction

    function automatic bit decode_hex(input logic [6:0] pins, output logic [3:0] nib);
        nib = '0;
        for (int v = 0; v < 16; v++)
            if ((~pins) == hex_font[v])
            begin
                nib = 4'(v);
                return 1'b1;
            end

        return 1'b0;
    endfunction

    task automatic check_value(input string what, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ws(input logic level, output bit ok);
        int cycles;

        cycles = 0;
        while (mic_ws !== level && cycles < ws_timeout)
        begin
            @(negedge clk);
            cycles++;
        end

        ok = (mic_ws === level);
        if (!ok)
        begin
            $display("timeout at %0t: mic_ws did not go to %0b within %0d cycles",
                     $time, level, ws_timeout);
            timeouts++;
        end
    endtask

    // watches one full scan round and rebuilds the shown value from the lit digits.
    task automatic read_display(output logic [23:0] value);
        int         lit_cycles [6];
        int         lit_now;
        logic [3:0] nib;

        value = '0;
        foreach (lit_cycles[n])
            lit_cycles[n] = 0;

        for (int c = 0; c < 6 * `SEG_SCAN_DIV; c++)
        begin
            @(negedge clk);
            lit_now = 0;

            for (int n = 0; n < 6; n++)
                if (hex[n] !== 7'h7f)
                begin
                    lit_now++;
                    lit_cycles[n]++;

                    if (decode_hex(hex[n], nib))
                        value[4 * n +: 4] = nib;
                    else
                    begin
                        $display("CHECK FAILED at %0t: hex%0d shows unknown pattern %b",
                                 $time, n, hex[n]);
                        errors++;
                    end
                end

            if (lit_now > 1)
            begin
                $display("CHECK FAILED at %0t: %0d digits lit at once", $time, lit_now);
                errors++;
            end
        end

        for (int n = 0; n < 6; n++)
            if (lit_cycles[n] != `SEG_SCAN_DIV)
            begin
                $display("CHECK FAILED at %0t: hex%0d lit for %0d cycles in one round",
                         $time, n, lit_cycles[n]);
                errors++;
            end
    endtask

    task automatic set_row(input int idx, input logic [23:0] sample, input logic clear,
                           input logic sw0, input logic [23:0] peak, input logic [3:0] leds,
                           input logic [23:0] shown);
        rows[idx] = '{sample: sample, rnd: 1'b0, clear: clear, sw0: sw0,
                      peak: peak, leds: leds, shown: shown};
    endtask

    // the sample and the expected values of a random row are filled in at run time.
    task automatic set_random_row(input int idx, input logic clear, input logic sw0);
        rows[idx] = '{sample: '0, rnd: 1'b1, clear: clear, sw0: sw0,
                      peak: '0, leds: '0, shown: '0};
    endtask

    task automatic fill_table();
        set_row( 0, 24'h000000, 1'b0, 1'b1, 24'h000000, 4'd0,  24'h000000);
        set_row( 1, 24'h001234, 1'b0, 1'b1, 24'h001234, 4'd0,  24'h001234);
        set_row( 2, 24'hffe000, 1'b0, 1'b1, 24'h002000, 4'd0,  24'h002000);
        set_row( 3, 24'h004000, 1'b0, 1'b0, 24'h004000, 4'd1,  24'h004000);
        set_row( 4, 24'h000100, 1'b0, 1'b0, 24'h004000, 4'd0,  24'h004000);
        set_row( 5, 24'h800000, 1'b0, 1'b1, 24'h800000, 4'd10, 24'h800000);
        set_row( 6, 24'h7fffff, 1'b0, 1'b0, 24'h800000, 4'd9,  24'h800000);
        set_row( 7, 24'hedcbaa, 1'b0, 1'b1, 24'h800000, 4'd7,  24'h123456);
        set_row( 8, 24'h0abcde, 1'b1, 1'b0, 24'h0abcde, 4'd6,  24'h0abcde);
        set_row( 9, 24'h000fff, 1'b0, 1'b0, 24'h0abcde, 4'd0,  24'h0abcde);
        set_row(10, 24'hffffff, 1'b0, 1'b1, 24'h0abcde, 4'd0,  24'h000001);
        set_row(11, 24'h000000, 1'b1, 1'b0, 24'h000000, 4'd0,  24'h000000);
        set_random_row(12, 1'b0, 1'b1);
        set_random_row(13, 1'b0, 1'b0);
        set_random_row(14, 1'b1, 1'b0);
        set_random_row(15, 1'b0, 1'b1);
    endtask

    initial
    begin
        row_t               row;
        logic [23:0]        live;
        logic [23:0]        peak_model;
        logic [23:0]        shown_model;
        logic [23:0]        shown;
        logic [3:0]         leds_model;
        logic [9:0]         exp_bar;
        logic signed [23:0] smp;
        integer             rnd_word;
        bit                 ok;

        fill_table();
        peak_model = '0;

        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        check_value("ledr after reset", {14'd0, ledr}, 24'd0);
        check_value("mic_ws after reset", {23'd0, mic_ws}, 24'd1);
        check_value("mic_sck after reset", {23'd0, mic_sck}, 24'd0);
        check_value("mic_lr", {23'd0, mic_lr}, 24'd0);
        for (int n = 0; n < 6; n++)
            check_value($sformatf("hex%0d after reset", n), {17'd0, hex[n]}, 24'h00007f);

        read_display(shown);
        check_value("display after reset", shown, 24'd0);

        for (int r = 0; r < n_rows && timeouts == 0; r++)
        begin
            row = rows[r];
            wait_ws(1'b1, ok);

            if (ok)
            begin
                if (row.rnd)
                begin
                    rnd_word   = $random(seed);
                    smp        = rnd_word[23:0];
                    smp        = smp >>> rnd_word[27:24];
                    row.sample = smp;
                end

                // a running model of the meter gives the expected values of random rows
                // and checks the table.
                if (row.clear)
                    peak_model = '0;
                live = magnitude(row.sample);
                if (live > peak_model)
                    peak_model = live;
                leds_model  = led_count(live);
                shown_model = row.sw0 ? live : peak_model;

                if (row.rnd)
                begin
                    row.peak  = peak_model;
                    row.leds  = leds_model;
                    row.shown = shown_model;
                end
                else if (row.peak !== peak_model || row.leds !== leds_model
                         || row.shown !== shown_model)
                begin
                    $display("table row %0d disagrees with the reference model", r);
                    errors++;
                end

                cur_sample = row.sample;
                sw[0]      = row.sw0;

                if (row.clear)
                begin
                    key[0] = 1'b0;
                    repeat (4) @(negedge clk);
                    key[0] = 1'b1;
                end

                wait_ws(1'b0, ok);
                if (ok)
                    wait_ws(1'b1, ok);

                if (ok)
                begin
                    exp_bar = '0;
                    for (int i = 0; i < int'(row.leds); i++)
                        exp_bar[i] = 1'b1;

                    check_value($sformatf("ledr in row %0d", r), {14'd0, ledr},
                                {14'd0, exp_bar});
                    read_display(shown);
                    check_value($sformatf("display in row %0d", r), shown, row.shown);
                end
            end
        end

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen
#(
    parameter int period = 20
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    // a free running clock with an even duty cycle.
    always
        #(period / 2) clk = ~clk;

endmodule
